/* source/emu_bus_pkg.sv */
package emu_bus_pkg;

    // Register port widths
    localparam int csr_addr_w = 12;
    localparam int csr_data_w = 32;
    localparam int csr_strb_w = csr_data_w / 8;

    // Write and read response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // Host side of the AXI-Lite register port
    typedef struct packed {
        logic                  awvalid;
        logic [csr_addr_w-1:0] awaddr;
        logic                  wvalid;
        logic [csr_data_w-1:0] wdata;
        logic [csr_strb_w-1:0] wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [csr_addr_w-1:0] araddr;
        logic                  rready;
    } csr_req_t;

    // Port side of the AXI-Lite register port
    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [csr_data_w-1:0] rdata;
        logic [1:0]            rresp;
    } csr_rsp_t;

endpackage

/* source/emu_csr_pkg.sv */
package emu_csr_pkg;

    import emu_bus_pkg::*;

    // Register map
    localparam logic [csr_addr_w-1:0] addr_stat      = 12'h000;
    localparam logic [csr_addr_w-1:0] addr_trig_stat = 12'h004;
    localparam logic [csr_addr_w-1:0] addr_cycle_lo  = 12'h008;
    localparam logic [csr_addr_w-1:0] addr_cycle_hi  = 12'h00C;
    localparam logic [csr_addr_w-1:0] addr_step      = 12'h010;

    // Number of trigger lines coming from the emulated design
    localparam int trig_w = 32;

    // Status register layout
    // step_trig is read only, up_stat and down_stat come from the design
    typedef struct packed {
        logic        step_trig;
        logic [24:0] spare;
        logic        down_stat;
        logic        up_stat;
        logic        down_req;
        logic        up_req;
        logic        dut_rst;
        logic        pause;
    } emu_stat_t;

    // One write word, seen as status bits or as a plain count
    typedef union packed {
        emu_stat_t             stat;
        logic [csr_data_w-1:0] count;
    } csr_word_u;

    // Accepted register write, valid for one cycle while en is high
    typedef struct packed {
        logic                  en;
        logic [csr_addr_w-1:0] addr;
        csr_word_u             data;
    } csr_wr_t;

    // Control lines toward the emulated design
    typedef struct packed {
        logic pause;
        logic dut_rst;
        logic up_req;
        logic down_req;
        logic ff_clk_en;
    } emu_ctrl_t;

endpackage

/* source/emu_csr_port.sv */
`timescale 1ns/1ns

module emu_csr_port
    import emu_bus_pkg::*, emu_csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  csr_req_t              req,
    output csr_rsp_t              rsp,
    output csr_wr_t               wr,
    input  emu_stat_t             stat,
    input  logic [csr_data_w-1:0] trig_stat,
    input  logic [csr_data_w-1:0] step,
    input  logic [63:0]           cycle
);

    // Write channel state
    logic [csr_addr_w-1:0] wr_addr_q;
    csr_word_u             wr_data_q;
    logic                  wr_addr_held;
    logic                  wr_data_held;
    logic                  wr_strb_err;
    logic                  wr_resp_pend;

    // Read channel state
    logic [csr_addr_w-1:0] rd_addr_q;
    logic [csr_data_w-1:0] rd_data_q;
    logic [csr_data_w-1:0] rd_word;
    logic                  rd_addr_held;
    logic                  rd_data_valid;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;
    logic wr_both_held;
    logic rd_capture;

    assign aw_fire      = req.awvalid && rsp.awready;
    assign w_fire       = req.wvalid && rsp.wready;
    assign b_fire       = rsp.bvalid && req.bready;
    assign ar_fire      = req.arvalid && rsp.arready;
    assign r_fire       = rsp.rvalid && req.rready;
    assign wr_both_held = wr_addr_held && wr_data_held;
    assign rd_capture   = rd_addr_held && !rd_data_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr_held <= 1'b0;
            wr_data_held <= 1'b0;
            wr_strb_err  <= 1'b0;
            wr_resp_pend <= 1'b0;
        end else begin
            if (aw_fire) begin
                wr_addr_held <= 1'b1;
            end
            if (w_fire) begin
                wr_data_held <= 1'b1;
                wr_strb_err  <= req.wstrb != {csr_strb_w{1'b1}};
            end
            // Address and data complete, release both and answer
            if (wr_both_held) begin
                wr_addr_held <= 1'b0;
                wr_data_held <= 1'b0;
                wr_resp_pend <= 1'b1;
            end
            if (b_fire) begin
                wr_resp_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            wr_addr_q <= req.awaddr;
        end
        if (w_fire) begin
            wr_data_q <= req.wdata;
        end
    end

    // Only full-strobe writes reach the registers
    assign wr = '{en: wr_both_held && !wr_strb_err, addr: wr_addr_q, data: wr_data_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_addr_held  <= 1'b0;
            rd_data_valid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_addr_held <= 1'b1;
            end
            if (rd_capture) begin
                rd_data_valid <= 1'b1;
            end
            if (r_fire) begin
                rd_addr_held  <= 1'b0;
                rd_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_addr_q <= req.araddr;
        end
        if (rd_capture) begin
            rd_data_q <= rd_word;
        end
    end

    // Readback select, holes in the map read as zero
    always_comb begin
        case (rd_addr_q)
            addr_stat:      rd_word = stat;
            addr_trig_stat: rd_word = trig_stat;
            addr_cycle_lo:  rd_word = cycle[31:0];
            addr_cycle_hi:  rd_word = cycle[63:32];
            addr_step:      rd_word = step;
            default:        rd_word = '0;
        endcase
    end

    assign rsp.awready = !wr_addr_held && !wr_resp_pend;
    assign rsp.wready  = !wr_data_held;
    assign rsp.bvalid  = wr_resp_pend;
    assign rsp.bresp   = wr_strb_err ? resp_slverr : resp_okay;
    assign rsp.arready = !rd_addr_held;
    assign rsp.rvalid  = rd_data_valid;
    assign rsp.rdata   = rd_data_q;
    assign rsp.rresp   = resp_okay;

endmodule

/* source/emu_run_ctrl.sv */
`timescale 1ns/1ns

module emu_run_ctrl
    import emu_csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  csr_wr_t           wr,
    input  logic [trig_w-1:0] dut_trig,
    input  logic              up_stat,
    input  logic              down_stat,
    input  logic              model_stall,
    output emu_stat_t         stat,
    output logic [trig_w-1:0] trig_stat,
    output logic [31:0]       step,
    output emu_ctrl_t         ctrl
);

    logic pause;
    logic dut_rst;
    logic up_req;
    logic down_req;
    logic step_trig_q;

    logic [31:0] step_next;
    logic        step_trig;
    logic        trigger;
    logic        stat_wr;
    logic        step_wr;

    assign stat_wr = wr.en && wr.addr == addr_stat;
    assign step_wr = wr.en && wr.addr == addr_step;

    // Countdown only moves while running
    always_comb begin
        if (pause) begin
            step_next = step;
        end else if (step != 32'd0) begin
            step_next = step - 32'd1;
        end else begin
            step_next = 32'd0;
        end
    end

    // Step expiry is the one to zero transition
    assign step_trig = step != 32'd0 && step_next == 32'd0;
    assign trigger   = step_trig || |dut_trig;

    always_ff @(posedge clk) begin
        if (rst) begin
            pause       <= 1'b1;
            dut_rst     <= 1'b1;
            up_req      <= 1'b0;
            down_req    <= 1'b0;
            step_trig_q <= 1'b0;
        end else if (trigger) begin
            // Trigger overrides any status write in the same cycle
            pause       <= 1'b1;
            step_trig_q <= step_trig;
        end else if (stat_wr) begin
            pause    <= wr.data.stat.pause;
            dut_rst  <= wr.data.stat.dut_rst;
            up_req   <= wr.data.stat.up_req;
            down_req <= wr.data.stat.down_req;
        end
    end

    // Pattern of the design triggers at the stopping edge
    always_ff @(posedge clk) begin
        if (rst) begin
            trig_stat <= '0;
        end else if (trigger) begin
            trig_stat <= dut_trig;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= 32'd0;
        end else if (step_wr) begin
            step <= wr.data.count;
        end else begin
            step <= step_next;
        end
    end

    always_comb begin
        stat           = '0;
        stat.step_trig = step_trig_q;
        stat.down_stat = down_stat;
        stat.up_stat   = up_stat;
        stat.down_req  = down_req;
        stat.up_req    = up_req;
        stat.dut_rst   = dut_rst;
        stat.pause     = pause;
    end

    assign ctrl.pause     = pause;
    assign ctrl.dut_rst   = dut_rst;
    assign ctrl.up_req    = up_req;
    assign ctrl.down_req  = down_req;
    // Design clock runs when not paused and the model is not stalling
    assign ctrl.ff_clk_en = !pause && !model_stall;

endmodule

/* source/emu_cycle_counter.sv */
`timescale 1ns/1ns

module emu_cycle_counter
    import emu_csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  csr_wr_t     wr,
    input  logic        pause,
    output logic [63:0] cycle
);

    logic lo_wr;
    logic hi_wr;

    assign lo_wr = wr.en && wr.addr == addr_cycle_lo;
    assign hi_wr = wr.en && wr.addr == addr_cycle_hi;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= 64'd0;
        end else if (!pause) begin
            // Running, host writes are dropped
            cycle <= cycle + 64'd1;
        end else begin
            if (lo_wr) begin
                cycle[31:0] <= wr.data.count;
            end
            if (hi_wr) begin
                cycle[63:32] <= wr.data.count;
            end
        end
    end

endmodule

/* source/emu_control_top.sv */
`timescale 1ns/1ns

module emu_control_top
    import emu_bus_pkg::*, emu_csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  csr_req_t          req,
    output csr_rsp_t          rsp,
    input  logic [trig_w-1:0] dut_trig,
    input  logic              up_stat,
    input  logic              down_stat,
    input  logic              model_stall,
    output emu_ctrl_t         ctrl
);

    csr_wr_t           wr;
    emu_stat_t         stat;
    logic [trig_w-1:0] trig_stat;
    logic [31:0]       step;
    logic [63:0]       cycle;

    // Host register port
    emu_csr_port u_port (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .rsp       (rsp),
        .wr        (wr),
        .stat      (stat),
        .trig_stat (trig_stat),
        .step      (step),
        .cycle     (cycle)
    );

    emu_run_ctrl u_run (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .dut_trig    (dut_trig),
        .up_stat     (up_stat),
        .down_stat   (down_stat),
        .model_stall (model_stall),
        .stat        (stat),
        .trig_stat   (trig_stat),
        .step        (step),
        .ctrl        (ctrl)
    );

    // Counter follows the run state
    emu_cycle_counter u_cycle (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr),
        .pause (ctrl.pause),
        .cycle (cycle)
    );

endmodule

/* test/emu_control_checker.sv */
`timescale 1ns/1ns

module emu_control_checker
    import emu_bus_pkg::*, emu_csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  csr_req_t          req,
    input  csr_rsp_t          rsp,
    input  emu_ctrl_t         ctrl,
    input  logic [trig_w-1:0] dut_trig,
    input  logic              up_stat,
    input  logic              down_stat,
    input  logic              model_stall,
    output int                errors
);

    // Register model
    logic        m_pause, m_dut_rst, m_up_req, m_down_req, m_step_trig;
    logic [31:0] m_trig_stat, m_step;
    logic [63:0] m_cycle;

    // Host transfer tracking
    logic        a_held, d_held, strb_err, b_err, cap_next, wr_now, step_hit, trig;
    logic [11:0] a_addr, r_addr;
    logic [31:0] d_data, r_exp;
    int          err_count = 0;

    assign errors = err_count;

    function automatic logic [31:0] read_word(input logic [11:0] addr);
        case (addr)
            addr_stat: return {m_step_trig, 25'd0, down_stat, up_stat, m_down_req, m_up_req,
                               m_dut_rst, m_pause};
            addr_trig_stat: return m_trig_stat;
            addr_cycle_lo:  return m_cycle[31:0];
            addr_cycle_hi:  return m_cycle[63:32];
            addr_step:      return m_step;
            default:        return 32'd0;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            {m_pause, m_dut_rst, m_up_req, m_down_req, m_step_trig} = 5'b11000;
            m_trig_stat = '0;
            m_step      = '0;
            m_cycle     = '0;
            {a_held, d_held, strb_err, b_err, cap_next} = '0;
        end else begin
            check_val("ctrl.pause", 64'(ctrl.pause), 64'(m_pause));
            check_val("ctrl.dut_rst", 64'(ctrl.dut_rst), 64'(m_dut_rst));
            check_val("ctrl.up_req", 64'(ctrl.up_req), 64'(m_up_req));
            check_val("ctrl.down_req", 64'(ctrl.down_req), 64'(m_down_req));
            check_val("ctrl.ff_clk_en", 64'(ctrl.ff_clk_en), 64'(!m_pause && !model_stall));

            if (rsp.rvalid && req.rready) begin
                check_val("rdata", 64'(rsp.rdata), 64'(r_exp));
            end
            // Read data is taken one edge after the address
            if (cap_next) begin
                r_exp    = read_word(r_addr);
                cap_next = 1'b0;
            end
            if (req.arvalid && rsp.arready) begin
                r_addr   = req.araddr;
                cap_next = 1'b1;
            end

            if (rsp.bvalid && req.bready) begin
                check_val("bresp", 64'(rsp.bresp), 64'(b_err ? resp_slverr : resp_okay));
            end
            wr_now = 1'b0;
            if (a_held && d_held) begin
                wr_now = !strb_err;
                b_err  = strb_err;
                a_held = 1'b0;
                d_held = 1'b0;
            end
            if (req.awvalid && rsp.awready) begin
                a_held = 1'b1;
                a_addr = req.awaddr;
            end
            if (req.wvalid && rsp.wready) begin
                d_held   = 1'b1;
                d_data   = req.wdata;
                strb_err = req.wstrb != 4'hf;
            end

            step_hit = !m_pause && m_step == 32'd1;
            trig     = step_hit || dut_trig != '0;
            if (!m_pause) begin
                m_cycle = m_cycle + 64'd1;
            end else if (wr_now && a_addr == addr_cycle_lo) begin
                m_cycle[31:0] = d_data;
            end else if (wr_now && a_addr == addr_cycle_hi) begin
                m_cycle[63:32] = d_data;
            end
            if (wr_now && a_addr == addr_step) begin
                m_step = d_data;
            end else if (!m_pause && m_step != 32'd0) begin
                m_step = m_step - 32'd1;
            end
            if (trig) begin
                m_pause     = 1'b1;
                m_step_trig = step_hit;
                m_trig_stat = dut_trig;
            end else if (wr_now && a_addr == addr_stat) begin
                {m_down_req, m_up_req, m_dut_rst, m_pause} = d_data[3:0];
            end
        end
    end

endmodule

/* test/emu_control_assertions.sv */
`timescale 1ns/1ns

module emu_control_assertions
    import emu_bus_pkg::*, emu_csr_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input csr_rsp_t  rsp,
    input emu_ctrl_t ctrl
);

    // Write back-pressure
    assert property (@(posedge clk) disable iff (rst) rsp.bvalid |-> !rsp.awready)
        else $error("awready high while a write response is pending");

    assert property (@(posedge clk) disable iff (rst) rsp.rresp == resp_okay)
        else $error("read response is not okay");

    assert property (@(posedge clk) disable iff (rst) ctrl.pause |-> !ctrl.ff_clk_en)
        else $error("design clock enabled while paused");

endmodule

// Each instance watches one side, the other side is tied to a quiet value
bind emu_csr_port emu_control_assertions port_asrt (
    .clk(clk), .rst(rst), .rsp(rsp), .ctrl(5'b10000)
);
bind emu_run_ctrl emu_control_assertions run_asrt (
    .clk(clk), .rst(rst), .rsp('0), .ctrl(ctrl)
);

/* test/emu_control_tb.sv */
`timescale 1ns/1ns

module emu_control_tb
    import emu_bus_pkg::*, emu_csr_pkg::*;
;

    // Rough cycles per test, summed for the watchdog
    localparam int total_cycles = 60 + 120 + 60 + 120 + 60 + 200;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    csr_req_t          req;
    csr_rsp_t          rsp;
    logic [trig_w-1:0] dut_trig;
    logic              up_stat, down_stat, model_stall, wiggle;
    emu_ctrl_t         ctrl;
    int                errors, err_start, passed, failed;
    logic [11:0]       addr;

    emu_control_top dut0 (.clk, .rst, .req, .rsp, .dut_trig, .up_stat, .down_stat,
                          .model_stall, .ctrl);
    emu_control_checker chk0 (.clk, .rst, .req, .rsp, .ctrl, .dut_trig, .up_stat,
                              .down_stat, .model_stall, .errors);

    initial begin
        forever #50 clk = !clk;
    end

    initial begin
        #(total_cycles * 4 * 100);
        $display("watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

    // Random design inputs while enabled
    always @(negedge clk) begin
        if (wiggle) begin
            model_stall <= 1'($urandom());
            up_stat     <= 1'($urandom());
            down_stat   <= 1'($urandom());
        end
    end

    task automatic write_reg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
        logic aw_hs, w_hs;
        @(negedge clk);
        {req.awvalid, req.wvalid, req.bready} = 3'b111;
        req.awaddr = a;
        req.wdata  = d;
        req.wstrb  = s;
        while (req.awvalid || req.wvalid) begin
            aw_hs = req.awvalid && rsp.awready;
            w_hs  = req.wvalid && rsp.wready;
            @(negedge clk);
            if (aw_hs) req.awvalid = 1'b0;
            if (w_hs) req.wvalid = 1'b0;
        end
        while (!rsp.bvalid) @(negedge clk);
        @(negedge clk);
        req.bready = 1'b0;
    endtask

    task automatic read_reg(input logic [11:0] a);
        @(negedge clk);
        req.arvalid = 1'b1;
        req.araddr  = a;
        while (!rsp.arready) @(negedge clk);
        @(negedge clk);
        req.arvalid = 1'b0;
        req.rready  = 1'b1;
        while (!rsp.rvalid) @(negedge clk);
        @(negedge clk);
        req.rready = 1'b0;
    endtask

    task automatic end_test(input string name);
        if (errors == err_start) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
        err_start = errors;
    endtask

    initial begin
        void'($urandom(10770));
        req = '0;
        {dut_trig, up_stat, down_stat, model_stall, wiggle} = '0;
        {err_start, passed, failed} = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_reg(addr_stat);
        read_reg(addr_trig_stat);
        read_reg(addr_cycle_lo);
        read_reg(addr_cycle_hi);
        read_reg(addr_step);
        read_reg(12'h100);
        end_test("reset values");

        repeat (8) begin
            addr = 12'h008 + 12'($urandom_range(0, 2) * 4);
            write_reg(addr, $urandom(), 4'hf);
            read_reg(addr);
        end
        end_test("paused register writes");

        repeat (4) begin
            addr = $urandom_range(0, 1) ? addr_step : addr_cycle_lo;
            write_reg(addr, $urandom(), 4'($urandom_range(1, 14)));
            read_reg(addr);
        end
        end_test("partial strobe writes");

        write_reg(addr_step, $urandom_range(1, 40), 4'hf);
        write_reg(addr_stat, 32'h0, 4'hf);
        while (!ctrl.pause) @(negedge clk);
        read_reg(addr_stat);
        read_reg(addr_step);
        read_reg(addr_cycle_lo);
        read_reg(addr_cycle_hi);
        end_test("step run");

        write_reg(addr_stat, 32'h0, 4'hf);
        dut_trig = $urandom();
        if (dut_trig == '0) dut_trig = 32'h1;
        @(negedge clk);
        dut_trig = '0;
        while (!ctrl.pause) @(negedge clk);
        read_reg(addr_trig_stat);
        read_reg(addr_stat);
        end_test("design trigger");

        wiggle = 1'b1;
        repeat (10) begin
            write_reg(addr_stat, 32'($urandom_range(0, 15)), 4'hf);
            read_reg(addr_stat);
        end
        wiggle = 1'b0;
        end_test("requests and clock enable");

        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
source/emu_bus_pkg.sv
source/emu_csr_pkg.sv
source/emu_csr_port.sv
source/emu_run_ctrl.sv
source/emu_cycle_counter.sv
source/emu_control_top.sv
test/emu_control_checker.sv
test/emu_control_assertions.sv
test/emu_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module emu_control_tb -f vlog.f -o emu_sim

# The simulator exits cleanly on failure too, so the log decides
./obj_dir/emu_sim | tee sim.log

if grep -q "Something failed" sim.log; then
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "run ended without a result"
    exit 1
fi
exit 0
